// ==== source/core_pkg.sv ====
package core_pkg;

  // data and address width of the integer pipeline
  localparam int XLEN = 64;

  // load operation carried from execute
  typedef enum logic [2:0] {
    LD_NONE = 3'd0,
    LD_LB   = 3'd1,
    LD_LH   = 3'd2,
    LD_LW   = 3'd3,
    LD_LD   = 3'd4,
    LD_LBU  = 3'd5,
    LD_LHU  = 3'd6,
    LD_LWU  = 3'd7
  } load_op_e;

  // store operation carried from execute
  typedef enum logic [2:0] {
    ST_NONE = 3'd0,
    ST_SB   = 3'd1,
    ST_SH   = 3'd2,
    ST_SW   = 3'd3,
    ST_SD   = 3'd4
  } store_op_e;

  // access size on the request port
  typedef enum logic [1:0] {
    SZ_B = 2'd0,
    SZ_H = 2'd1,
    SZ_W = 2'd2,
    SZ_D = 2'd3
  } size_e;

  // byte count of an access size
  function automatic int unsigned size_bytes(size_e sz);
    int unsigned n;
    case (sz)
      SZ_B: n = 1;
      SZ_H: n = 2;
      SZ_W: n = 4;
      default: n = 8;
    endcase
    return n;
  endfunction

endpackage

// ==== source/load_extend.sv ====
`timescale 1ns/10ps

module load_extend (
  input  core_pkg::load_op_e           load_op,
  input  logic [core_pkg::XLEN-1:0]    raw,
  output logic [core_pkg::XLEN-1:0]    data
);

  // addressed bytes already sit at bit 0 of raw
  always_comb begin
    case (load_op)
      core_pkg::LD_LB: begin
        data = {{56{raw[7]}}, raw[7:0]};
      end
      core_pkg::LD_LH: begin
        data = {{48{raw[15]}}, raw[15:0]};
      end
      core_pkg::LD_LW: begin
        data = {{32{raw[31]}}, raw[31:0]};
      end
      core_pkg::LD_LD: begin
        data = raw;
      end
      core_pkg::LD_LBU: begin
        data = {56'd0, raw[7:0]};
      end
      core_pkg::LD_LHU: begin
        data = {48'd0, raw[15:0]};
      end
      core_pkg::LD_LWU: begin
        data = {32'd0, raw[31:0]};
      end
      default: begin
        // not a load
        data = '0;
      end
    endcase
  end

endmodule

// ==== source/store_trace.sv ====
`timescale 1ns/10ps

module store_trace (
  input  core_pkg::size_e              size,
  input  logic [core_pkg::XLEN-1:0]    addr,
  input  logic [core_pkg::XLEN-1:0]    wdata,
  output logic [core_pkg::XLEN-1:0]    trace_addr,
  output logic [core_pkg::XLEN-1:0]    trace_data,
  output logic [7:0]                   trace_mask
);

  logic [core_pkg::XLEN-1:0] replicated;
  logic [core_pkg::XLEN-1:0] lane_bits;
  logic [7:0]                size_mask;

  // word-aligned address for the checker
  assign trace_addr = {addr[core_pkg::XLEN-1:3], 3'b000};

  // store value copied into every lane of its width
  always_comb begin
    case (size)
      core_pkg::SZ_B: replicated = {8{wdata[7:0]}};
      core_pkg::SZ_H: replicated = {4{wdata[15:0]}};
      core_pkg::SZ_W: replicated = {2{wdata[31:0]}};
      default:        replicated = wdata;
    endcase
  end

  // one bit per byte, 1, 3, 15 or 255 before the shift
  assign size_mask  = 8'((9'd1 << core_pkg::size_bytes(size)) - 9'd1);
  assign trace_mask = size_mask << addr[2:0];

  // widen the byte mask to a bit mask
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      lane_bits[i*8 +: 8] = {8{trace_mask[i]}};
    end
  end

  // keep only the lanes the store touches
  assign trace_data = replicated & lane_bits;

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/10ps

module mem_stage (
  input  logic                         clk,
  input  logic                         rst,
  // from execute
  input  logic                         ex_valid,
  input  logic [core_pkg::XLEN-1:0]    ex_pc,
  input  core_pkg::load_op_e           ex_load_op,
  input  core_pkg::store_op_e          ex_store_op,
  input  logic [core_pkg::XLEN-1:0]    ex_addr,
  input  logic [core_pkg::XLEN-1:0]    ex_store_data,
  input  logic [core_pkg::XLEN-1:0]    ex_alu_result,
  input  logic [4:0]                   ex_rd,
  input  logic                         ex_rd_wen,
  output logic                         allowin,
  // to write-back
  output logic                         wb_valid,
  output logic [core_pkg::XLEN-1:0]    wb_pc,
  output logic [4:0]                   wb_rd,
  output logic                         wb_rd_wen,
  output logic [core_pkg::XLEN-1:0]    wb_data,
  input  logic                         wb_allowin,
  // forwarding
  output logic [4:0]                   fwd_rd,
  output logic                         fwd_wen,
  output logic                         fwd_is_load,
  output logic [core_pkg::XLEN-1:0]    fwd_data,
  // store trace
  output logic                         trace_valid,
  output logic [core_pkg::XLEN-1:0]    trace_addr,
  output logic [core_pkg::XLEN-1:0]    trace_data,
  output logic [7:0]                   trace_mask,
  // request port
  output logic                         rw_valid,
  output logic                         rw_write,
  output logic [core_pkg::XLEN-1:0]    rw_addr,
  output core_pkg::size_e              rw_size,
  output logic [core_pkg::XLEN-1:0]    rw_wdata,
  input  logic                         ready,
  input  logic [core_pkg::XLEN-1:0]    rdata
);

  typedef enum logic [1:0] {IDLE, ADDR, RETN} state_e;

  state_e                    state;
  state_e                    state_next;
  logic                      valid_r;
  logic [core_pkg::XLEN-1:0] pc_r;
  logic [core_pkg::XLEN-1:0] addr_r;
  logic [core_pkg::XLEN-1:0] store_data_r;
  logic [core_pkg::XLEN-1:0] alu_result_r;
  logic [core_pkg::XLEN-1:0] load_data_r;
  core_pkg::load_op_e        load_op_r;
  core_pkg::store_op_e       store_op_r;
  logic [4:0]                rd_r;
  logic                      rd_wen_r;
  logic                      ready_go;
  logic                      ex_fire;
  logic                      wb_fire;
  logic                      rw_fire;
  logic                      ex_is_mem;
  logic                      is_load;
  logic                      is_store;
  logic [core_pkg::XLEN-1:0] width_mask;
  logic [core_pkg::XLEN-1:0] load_ext;

  assign ex_fire   = ex_valid && allowin;
  assign wb_fire   = wb_valid && wb_allowin;
  assign rw_fire   = rw_valid && ready;
  assign ex_is_mem = (ex_load_op != core_pkg::LD_NONE) || (ex_store_op != core_pkg::ST_NONE);
  assign is_load   = load_op_r != core_pkg::LD_NONE;
  assign is_store  = store_op_r != core_pkg::ST_NONE;

  // only an outstanding request keeps the record from leaving
  assign ready_go = state != ADDR;
  assign allowin  = !valid_r || (ready_go && wb_allowin);

  // pipeline register
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_r <= 1'b0;
    end else if (allowin) begin
      valid_r <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_fire) begin
      pc_r         <= ex_pc;
      load_op_r    <= ex_load_op;
      store_op_r   <= ex_store_op;
      addr_r       <= ex_addr;
      store_data_r <= ex_store_data;
      alu_result_r <= ex_alu_result;
      rd_r         <= ex_rd;
      rd_wen_r     <= ex_rd_wen;
    end
  end

  // access FSM
  always_comb begin
    state_next = state;
    if (ex_fire) begin
      state_next = ex_is_mem ? ADDR : IDLE;
    end else if (state == ADDR && rw_fire) begin
      state_next = RETN;
    end else if (wb_fire) begin
      state_next = IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // access size from whichever op is present
  always_comb begin
    case (store_op_r)
      core_pkg::ST_SB: rw_size = core_pkg::SZ_B;
      core_pkg::ST_SH: rw_size = core_pkg::SZ_H;
      core_pkg::ST_SW: rw_size = core_pkg::SZ_W;
      core_pkg::ST_SD: rw_size = core_pkg::SZ_D;
      default: begin
        case (load_op_r)
          core_pkg::LD_LB, core_pkg::LD_LBU: rw_size = core_pkg::SZ_B;
          core_pkg::LD_LH, core_pkg::LD_LHU: rw_size = core_pkg::SZ_H;
          core_pkg::LD_LW, core_pkg::LD_LWU: rw_size = core_pkg::SZ_W;
          default:                           rw_size = core_pkg::SZ_D;
        endcase
      end
    endcase
  end

  always_comb begin
    case (rw_size)
      core_pkg::SZ_B: width_mask = 64'h0000_0000_0000_00ff;
      core_pkg::SZ_H: width_mask = 64'h0000_0000_0000_ffff;
      core_pkg::SZ_W: width_mask = 64'h0000_0000_ffff_ffff;
      default:        width_mask = '1;
    endcase
  end

  assign rw_valid = state == ADDR;
  assign rw_write = is_store;
  assign rw_addr  = addr_r;
  assign rw_wdata = store_data_r & width_mask;

  load_extend u_load_extend (
    .load_op (load_op_r),
    .raw     (rdata),
    .data    (load_ext)
  );

  // rdata is only valid in the transfer cycle
  always_ff @(posedge clk) begin
    if (rw_fire) begin
      load_data_r <= load_ext;
    end
  end

  // write-back record
  assign wb_valid  = valid_r && ready_go;
  assign wb_pc     = pc_r;
  assign wb_rd     = rd_r;
  assign wb_rd_wen = rd_wen_r;
  assign wb_data   = is_load ? load_data_r : alu_result_r;

  // forwarding, load result not yet usable
  assign fwd_rd      = rd_r;
  assign fwd_wen     = valid_r && rd_wen_r;
  assign fwd_is_load = valid_r && is_load;
  assign fwd_data    = alu_result_r;

  store_trace u_store_trace (
    .size       (rw_size),
    .addr       (addr_r),
    .wdata      (rw_wdata),
    .trace_addr (trace_addr),
    .trace_data (trace_data),
    .trace_mask (trace_mask)
  );

  assign trace_valid = wb_fire && is_store;

  // no request and no RAM answer while idle or empty
  assert property (@(posedge clk) disable iff (rst)
    (state == IDLE || !valid_r) |-> !rw_valid && !ready);

  assert property (@(posedge clk) disable iff (rst)
    rw_valid && !ready |=> rw_valid && $stable({rw_write, rw_addr, rw_size, rw_wdata}));

  // held record stays put under back-pressure
  assert property (@(posedge clk) disable iff (rst)
    wb_valid && !wb_allowin |=> wb_valid && $stable({wb_pc, wb_rd, wb_rd_wen, wb_data}));

endmodule

// ==== source/data_ram.sv ====
`timescale 1ns/10ps

module data_ram #(
  parameter int RAM_WORDS  = 256,
  parameter int RESP_DELAY = 2
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         rw_valid,
  input  logic                         rw_write,
  input  logic [core_pkg::XLEN-1:0]    rw_addr,
  input  core_pkg::size_e              rw_size,
  input  logic [core_pkg::XLEN-1:0]    rw_wdata,
  output logic                         ready,
  output logic [core_pkg::XLEN-1:0]    rdata
);

  localparam int          IDX_W = $clog2(RAM_WORDS);
  localparam logic [2:0]  DELAY = 3'(RESP_DELAY);

  logic [core_pkg::XLEN-1:0] mem [RAM_WORDS];
  logic [IDX_W-1:0]          idx;
  logic [2:0]                wait_cnt;
  logic [5:0]                bit_off;
  logic [7:0]                size_mask;
  logic [7:0]                byte_en;
  logic [core_pkg::XLEN-1:0] lane_data;
  logic                      fire;

  // contents start cleared
  initial begin
    for (int i = 0; i < RAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // word index, upper address bits ignored
  assign idx     = rw_addr[IDX_W+2:3];
  assign bit_off = {rw_addr[2:0], 3'b000};

  // cycles since rw_valid rose
  always_ff @(posedge clk) begin
    if (rst || !rw_valid || fire) begin
      wait_cnt <= 3'd0;
    end else begin
      wait_cnt <= wait_cnt + 3'd1;
    end
  end

  // combinational when the delay is zero
  assign ready = rw_valid && (wait_cnt == DELAY);
  assign fire  = rw_valid && ready;

  // lanes the write touches
  assign size_mask = 8'((9'd1 << core_pkg::size_bytes(rw_size)) - 9'd1);
  assign byte_en   = size_mask << rw_addr[2:0];
  assign lane_data = rw_wdata << bit_off;

  always_ff @(posedge clk) begin
    if (fire && rw_write) begin
      for (int i = 0; i < 8; i++) begin
        if (byte_en[i]) begin
          mem[idx][i*8 +: 8] <= lane_data[i*8 +: 8];
        end
      end
    end
  end

  // addressed bytes down to bit 0, upper bytes left for the extender to drop
  assign rdata = mem[idx] >> bit_off;

  // misaligned accesses are outside this design
  assert property (@(posedge clk) disable iff (rst)
    rw_valid |-> (rw_addr[2:0] & 3'(core_pkg::size_bytes(rw_size) - 1)) == 3'd0);

  // fixed response delay seen from the requester side
  assert property (@(posedge clk) disable iff (rst)
    $rose(rw_valid) |-> ##RESP_DELAY ready);

endmodule

// ==== source/mem_subsystem.sv ====
`timescale 1ns/10ps

module mem_subsystem #(
  parameter int RAM_WORDS  = 256,
  parameter int RESP_DELAY = 2
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         ex_valid,
  input  logic [core_pkg::XLEN-1:0]    ex_pc,
  input  core_pkg::load_op_e           ex_load_op,
  input  core_pkg::store_op_e          ex_store_op,
  input  logic [core_pkg::XLEN-1:0]    ex_addr,
  input  logic [core_pkg::XLEN-1:0]    ex_store_data,
  input  logic [core_pkg::XLEN-1:0]    ex_alu_result,
  input  logic [4:0]                   ex_rd,
  input  logic                         ex_rd_wen,
  output logic                         allowin,
  output logic                         wb_valid,
  output logic [core_pkg::XLEN-1:0]    wb_pc,
  output logic [4:0]                   wb_rd,
  output logic                         wb_rd_wen,
  output logic [core_pkg::XLEN-1:0]    wb_data,
  input  logic                         wb_allowin,
  output logic [4:0]                   fwd_rd,
  output logic                         fwd_wen,
  output logic                         fwd_is_load,
  output logic [core_pkg::XLEN-1:0]    fwd_data,
  output logic                         trace_valid,
  output logic [core_pkg::XLEN-1:0]    trace_addr,
  output logic [core_pkg::XLEN-1:0]    trace_data,
  output logic [7:0]                   trace_mask
);

  // request port between stage and RAM
  logic                      rw_valid;
  logic                      rw_write;
  logic [core_pkg::XLEN-1:0] rw_addr;
  core_pkg::size_e           rw_size;
  logic [core_pkg::XLEN-1:0] rw_wdata;
  logic                      ready;
  logic [core_pkg::XLEN-1:0] rdata;

  mem_stage u_mem_stage (
    .clk           (clk),
    .rst           (rst),
    .ex_valid      (ex_valid),
    .ex_pc         (ex_pc),
    .ex_load_op    (ex_load_op),
    .ex_store_op   (ex_store_op),
    .ex_addr       (ex_addr),
    .ex_store_data (ex_store_data),
    .ex_alu_result (ex_alu_result),
    .ex_rd         (ex_rd),
    .ex_rd_wen     (ex_rd_wen),
    .allowin       (allowin),
    .wb_valid      (wb_valid),
    .wb_pc         (wb_pc),
    .wb_rd         (wb_rd),
    .wb_rd_wen     (wb_rd_wen),
    .wb_data       (wb_data),
    .wb_allowin    (wb_allowin),
    .fwd_rd        (fwd_rd),
    .fwd_wen       (fwd_wen),
    .fwd_is_load   (fwd_is_load),
    .fwd_data      (fwd_data),
    .trace_valid   (trace_valid),
    .trace_addr    (trace_addr),
    .trace_data    (trace_data),
    .trace_mask    (trace_mask),
    .rw_valid      (rw_valid),
    .rw_write      (rw_write),
    .rw_addr       (rw_addr),
    .rw_size       (rw_size),
    .rw_wdata      (rw_wdata),
    .ready         (ready),
    .rdata         (rdata)
  );

  data_ram #(
    .RAM_WORDS  (RAM_WORDS),
    .RESP_DELAY (RESP_DELAY)
  ) u_data_ram (
    .clk      (clk),
    .rst      (rst),
    .rw_valid (rw_valid),
    .rw_write (rw_write),
    .rw_addr  (rw_addr),
    .rw_size  (rw_size),
    .rw_wdata (rw_wdata),
    .ready    (ready),
    .rdata    (rdata)
  );

endmodule

// ==== sim/mem_checker.sv ====
`timescale 1ns/10ps

module mem_checker #(
  parameter int RAM_WORDS  = 256,
  parameter int RESP_DELAY = 2
) (
  input  logic                clk, rst, ex_valid, ex_rd_wen, allowin, wb_allowin,
  input  logic                wb_valid, wb_rd_wen, fwd_wen, fwd_is_load, trace_valid,
  input  logic [63:0]         ex_pc, ex_addr, ex_store_data, ex_alu_result,
  input  logic [63:0]         wb_pc, wb_data, fwd_data, trace_addr, trace_data,
  input  core_pkg::load_op_e  ex_load_op,
  input  core_pkg::store_op_e ex_store_op,
  input  logic [4:0]          ex_rd, wb_rd, fwd_rd,
  input  logic [7:0]          trace_mask,
  output int                  error_count,
  output int                  retired_count
);

  typedef struct packed {
    logic [63:0] pc;
    logic [63:0] data;
    logic [63:0] alu;
    logic [63:0] taddr;
    logic [63:0] tdata;
    logic [7:0]  tmask;
    logic [4:0]  rd;
    logic        rd_wen;
    logic        is_load;
    logic        is_store;
    logic [31:0] accepted;
  } record_t;

  logic [7:0] shadow [RAM_WORDS*8];
  record_t    pending [$];
  record_t    head;
  record_t    rec;
  string      test_name = "reset";
  int         cycle;
  int         k;
  bit         seen;

  function automatic int byte_count(core_pkg::load_op_e ld, core_pkg::store_op_e st);
    case (ld)
      core_pkg::LD_LB, core_pkg::LD_LBU: return 1;
      core_pkg::LD_LH, core_pkg::LD_LHU: return 2;
      core_pkg::LD_LW, core_pkg::LD_LWU: return 4;
      core_pkg::LD_LD: return 8;
      default: begin
        case (st)
          core_pkg::ST_SB: return 1;
          core_pkg::ST_SH: return 2;
          core_pkg::ST_SW: return 4;
          default: return 8;
        endcase
      end
    endcase
  endfunction

  // expected write-back and trace fields from the shadow memory
  function automatic record_t reference(logic [63:0] pc, addr, sdata, alu,
      core_pkg::load_op_e ld, core_pkg::store_op_e st, logic [4:0] rd, logic rd_wen);
    record_t     r;
    int          n;
    int          off;
    int          b;
    logic [63:0] raw;
    logic        fill;
    r = '0;
    r.pc = pc;
    r.alu = alu;
    r.rd = rd;
    r.rd_wen = rd_wen;
    r.is_load = ld != core_pkg::LD_NONE;
    r.is_store = st != core_pkg::ST_NONE;
    r.data = alu;
    n = byte_count(ld, st);
    off = int'(addr[2:0]);
    if (r.is_load) begin
      raw = '0;
      for (b = 0; b < n; b++) begin
        raw[b*8 +: 8] = shadow[int'((addr + 64'(b)) % (RAM_WORDS * 8))];
      end
      // top loaded bit fills upward only for the signed loads
      fill = raw[n*8-1] && (ld == core_pkg::LD_LB || ld == core_pkg::LD_LH ||
                            ld == core_pkg::LD_LW);
      for (b = n * 8; b < 64; b++) begin
        raw[b] = fill;
      end
      r.data = raw;
    end
    if (r.is_store) begin
      r.taddr = addr & ~64'd7;
      for (b = off; b < off + n; b++) begin
        r.tmask[b] = 1'b1;
        r.tdata[b*8 +: 8] = sdata[(b-off)*8 +: 8];
      end
    end
    return r;
  endfunction

  task automatic compare(string field, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("mismatch test %s %s expected %h actual %h", test_name, field, expected,
               actual);
      error_count++;
    end
  endtask

  task automatic report(string what);
    $display("error in test %s: %s", test_name, what);
    error_count++;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      pending.delete();
      cycle = 0;
      seen = 0;
      error_count = 0;
      retired_count = 0;
      for (k = 0; k < RAM_WORDS * 8; k++) begin
        shadow[k] = 8'h00;
      end
    end else begin
      cycle++;
      // held instruction is the head of the queue
      if (pending.size() == 0) begin
        if (wb_valid) report("wb_valid high with no instruction in the stage");
        if (fwd_wen) report("fwd_wen high with no instruction in the stage");
      end else begin
        head = pending[0];
        compare("fwd_wen", 64'(head.rd_wen), 64'(fwd_wen));
        compare("fwd_rd", 64'(head.rd), 64'(fwd_rd));
        compare("fwd_is_load", 64'(head.is_load), 64'(fwd_is_load));
        compare("fwd_data", head.alu, fwd_data);
        if (wb_valid && !seen) begin
          seen = 1;
          compare("latency", (head.is_load || head.is_store) ? RESP_DELAY + 2 : 1,
                  64'(cycle - int'(head.accepted)));
        end
      end
      if (wb_valid && !wb_allowin && allowin) report("allowin high while a record is held");
      if (trace_valid && !(wb_valid && wb_allowin)) report("trace_valid without a handshake");
      if (wb_valid && wb_allowin) begin
        if (pending.size() == 0) begin
          report("write-back record with nothing outstanding");
        end else begin
          head = pending.pop_front();
          seen = 0;
          retired_count++;
          compare("wb_pc", head.pc, wb_pc);
          compare("wb_rd", 64'(head.rd), 64'(wb_rd));
          compare("wb_rd_wen", 64'(head.rd_wen), 64'(wb_rd_wen));
          compare("wb_data", head.data, wb_data);
          compare("trace_valid", 64'(head.is_store), 64'(trace_valid));
          if (head.is_store) begin
            compare("trace_addr", head.taddr, trace_addr);
            compare("trace_data", head.tdata, trace_data);
            compare("trace_mask", 64'(head.tmask), 64'(trace_mask));
          end
        end
      end
      if (ex_valid && allowin) begin
        rec = reference(ex_pc, ex_addr, ex_store_data, ex_alu_result, ex_load_op,
                        ex_store_op, ex_rd, ex_rd_wen);
        rec.accepted = 32'(cycle);
        // stores land in the shadow memory in program order
        for (k = 0; k < 8; k++) begin
          if (rec.tmask[k]) begin
            shadow[int'((rec.taddr + 64'(k)) % (RAM_WORDS * 8))] = rec.tdata[k*8 +: 8];
          end
        end
        pending.push_back(rec);
      end
    end
  end

endmodule

// ==== sim/tb_mem_subsystem.sv ====
`timescale 1ns/10ps

module tb_mem_subsystem;

  localparam int          RAM_WORDS  = 256;
  localparam int          RESP_DELAY = 2;
  localparam int          NUM_INSTR  = 400;
  localparam int          TIMEOUT    = NUM_INSTR * (RESP_DELAY + 8) + 200;
  localparam logic [63:0] BASE       = 64'h200;

  logic                clk, rst, ex_valid, ex_rd_wen, allowin, wb_allowin;
  logic                wb_valid, wb_rd_wen, fwd_wen, fwd_is_load, trace_valid;
  logic [63:0]         ex_pc, ex_addr, ex_store_data, ex_alu_result;
  logic [63:0]         wb_pc, wb_data, fwd_data, trace_addr, trace_data;
  core_pkg::load_op_e  ex_load_op;
  core_pkg::store_op_e ex_store_op;
  logic [4:0]          ex_rd, wb_rd, fwd_rd;
  logic [7:0]          trace_mask;
  int                  error_count;
  int                  retired_count;
  logic [31:0]         seed;
  logic [63:0]         pc_next;
  bit                  stall_mode;
  int                  issued;
  int                  cycles = 0;
  int                  errors_before;
  int                  groups_passed;
  int                  groups_failed;

  mem_subsystem #(.RAM_WORDS(RAM_WORDS), .RESP_DELAY(RESP_DELAY)) UUT (.*);

  mem_checker #(.RAM_WORDS(RAM_WORDS), .RESP_DELAY(RESP_DELAY)) checks (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, stopped waiting for write-back records", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int unsigned pick(int unsigned range);
    return (next_random() >> 8) % range;
  endfunction

  // log2 of the access size of a load
  function automatic int unsigned size_index(core_pkg::load_op_e ld);
    case (ld)
      core_pkg::LD_LB, core_pkg::LD_LBU: return 0;
      core_pkg::LD_LH, core_pkg::LD_LHU: return 1;
      core_pkg::LD_LW, core_pkg::LD_LWU: return 2;
      default: return 3;
    endcase
  endfunction

  // naturally aligned address in a 64-word window
  function automatic logic [63:0] place(int unsigned word, int unsigned n);
    return BASE + 64'(word * 8) + 64'(pick(8 / n) * n);
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
    wb_allowin = stall_mode ? (pick(8) >= 3) : 1'b1;
  endtask

  task automatic send(core_pkg::load_op_e ld, core_pkg::store_op_e st, logic [63:0] addr);
    logic taken;
    ex_valid = 1'b1;
    ex_pc = pc_next;
    ex_load_op = ld;
    ex_store_op = st;
    ex_addr = addr;
    ex_store_data = {next_random(), next_random()};
    ex_alu_result = (ld == core_pkg::LD_NONE && st == core_pkg::ST_NONE) ?
                    {next_random(), next_random()} : addr;
    ex_rd = 5'(pick(32));
    ex_rd_wen = (st == core_pkg::ST_NONE) && (pick(4) != 0);
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = allowin;
      next_cycle();
    end
    ex_valid = 1'b0;
    pc_next = pc_next + 64'd4;
    issued++;
    if (stall_mode) repeat (pick(3)) next_cycle();
  endtask

  task automatic store_then_load();
    core_pkg::load_op_e ld;
    int unsigned        sz;
    logic [63:0]        addr;
    ld = core_pkg::load_op_e'(3'(pick(7) + 1));
    sz = size_index(ld);
    addr = place(pick(64), 1 << sz);
    send(core_pkg::LD_NONE, core_pkg::store_op_e'(3'(sz + 1)), addr);
    send(ld, core_pkg::ST_NONE, addr);
  endtask

  // kind 0 store, 1 load, 2 non-memory
  task automatic send_random(int unsigned kinds);
    int unsigned        kind;
    int unsigned        sz;
    core_pkg::load_op_e ld;
    kind = pick(kinds);
    sz = pick(4);
    ld = core_pkg::load_op_e'(3'(pick(7) + 1));
    if (kind == 0) begin
      send(core_pkg::LD_NONE, core_pkg::store_op_e'(3'(sz + 1)), place(pick(64), 1 << sz));
    end else if (kind == 1) begin
      send(ld, core_pkg::ST_NONE, place(pick(64), 1 << size_index(ld)));
    end else begin
      send(core_pkg::LD_NONE, core_pkg::ST_NONE, {next_random(), next_random()});
    end
  endtask

  task automatic start_group(string name, bit backpressure);
    checks.test_name = name;
    errors_before = error_count;
    stall_mode = backpressure;
  endtask

  task automatic finish_group(string name);
    while (retired_count < issued) next_cycle();
    if (error_count == errors_before) begin
      $display("test %s passed", name);
      groups_passed++;
    end else begin
      $display("test %s failed with %0d errors", name, error_count - errors_before);
      groups_failed++;
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    ex_valid = 1'b0;
    ex_pc = '0;
    ex_load_op = core_pkg::LD_NONE;
    ex_store_op = core_pkg::ST_NONE;
    ex_addr = '0;
    ex_store_data = '0;
    ex_alu_result = '0;
    ex_rd = '0;
    ex_rd_wen = 1'b0;
    wb_allowin = 1'b1;
    seed = 32'd5;
    pc_next = 64'h1000;
    stall_mode = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    start_group("store_load", 0);
    repeat (60) store_then_load();
    finish_group("store_load");
    start_group("store_trace", 0);
    repeat (60) send_random(1);
    finish_group("store_trace");
    start_group("alu_mixed", 0);
    repeat (80) send_random(3);
    finish_group("alu_mixed");
    start_group("back_pressure", 1);
    repeat (80) send_random(3);
    finish_group("back_pressure");
    start_group("latency", 0);
    repeat (60) send_random(3);
    finish_group("latency");
    $display("groups passed %0d, groups failed %0d", groups_passed, groups_failed);
    if (groups_failed == 0 && error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
source/core_pkg.sv
source/load_extend.sv
source/store_trace.sv
source/mem_stage.sv
source/data_ram.sv
source/mem_subsystem.sv
sim/mem_checker.sv
sim/tb_mem_subsystem.sv
